// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // ************************************************************************
  // widths.
  // ************************************************************************
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int nregs      = 32;
  localparam int alu_op_w   = 4;

  // major opcodes kept from rv32i.
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;
  localparam logic [2:0] f3_word = 3'b010;  // lw and sw.

  localparam logic [6:0] alt_funct7 = 7'b0100000;  // sub and sra.

  localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
  localparam logic [alu_op_w-1:0] alu_sll    = 4'd2;
  localparam logic [alu_op_w-1:0] alu_slt    = 4'd3;
  localparam logic [alu_op_w-1:0] alu_sltu   = 4'd4;
  localparam logic [alu_op_w-1:0] alu_xor    = 4'd5;
  localparam logic [alu_op_w-1:0] alu_srl    = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sra    = 4'd7;
  localparam logic [alu_op_w-1:0] alu_or     = 4'd8;
  localparam logic [alu_op_w-1:0] alu_and    = 4'd9;
  localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;  // lui.

  localparam logic [1:0] fwd_reg = 2'd0;
  localparam logic [1:0] fwd_mem = 2'd1;
  localparam logic [1:0] fwd_wb  = 2'd2;

  // one instruction word seen in three formats.
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } r_view;
    struct packed {
      logic [11:0]           imm11_0;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } i_view;
    struct packed {
      logic [6:0]            imm11_5;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            imm4_0;
      logic [6:0]            opcode;
    } s_view;
  } instr_u;

  localparam instr_u nop_instr = 32'h00000013;  // addi x0, x0, 0.

endpackage

`default_nettype wire

// File: source/pipe_buses.sv
`timescale 1ns/1ns
`default_nettype none

// decode to execute.
interface dec_ex_bus import rv_pkg::*; ();
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       imm;
  logic [alu_op_w-1:0]   alu_op;
  logic                  use_imm;
  logic                  mem_read;
  logic                  mem_write;
  logic                  reg_write;

  modport src (output rs1, rs2, rd, rs1_data, rs2_data, imm, alu_op, use_imm,
               mem_read, mem_write, reg_write);
  modport dst (input rs1, rs2, rd, rs1_data, rs2_data, imm, alu_op, use_imm,
               mem_read, mem_write, reg_write);
endinterface

// execute to memory.
interface ex_mem_bus import rv_pkg::*; ();
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       result;
  logic [xlen-1:0]       store_data;
  logic                  mem_read;
  logic                  mem_write;
  logic                  reg_write;

  modport src (output rd, result, store_data, mem_read, mem_write, reg_write);
  modport dst (input rd, result, store_data, mem_read, mem_write, reg_write);
  modport fwd (input rd, reg_write, result);
endinterface

// writeback port of the register file.
interface wb_bus import rv_pkg::*; ();
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       wdata;
  logic                  reg_write;

  modport src (output rd, wdata, reg_write);
  modport rf  (input rd, wdata, reg_write);
  modport fwd (input rd, wdata, reg_write);
endinterface

`default_nettype wire

// File: source/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            stall,
  output logic [xlen-1:0] imem_addr,
  input  logic [xlen-1:0] imem_instr,
  output instr_u          instr
);

  logic [xlen-1:0] pc;

  assign imem_addr = pc;  // imem answers in the same cycle.

  // pc and fetch/decode register both freeze on a load-use stall.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc    <= '0;
      instr <= nop_instr;
    end else if (!stall) begin
      pc    <= pc + 32'd4;
      instr <= imem_instr;
    end
  end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  instr_u                instr,
  wb_bus.rf                     wb,
  input  logic [reg_addr_w-1:0] ex_load_rd,
  input  logic                  ex_is_load,
  output logic                  stall,
  dec_ex_bus.src                dx
);

  logic [xlen-1:0]       regs [nregs];
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic                  alt;
  logic [xlen-1:0]       imm_i;
  logic [xlen-1:0]       imm_s;
  logic [xlen-1:0]       imm_u;
  logic [xlen-1:0]       imm;
  logic [alu_op_w-1:0]   alu_op;
  logic                  use_imm;
  logic                  mem_read;
  logic                  mem_write;
  logic                  reg_write;
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;

  function automatic logic [alu_op_w-1:0] arith_op(
    input logic [2:0] f3,
    input logic       alt_add,
    input logic       alt_shift
  );
    case (f3)
      f3_add:  return alt_add ? alu_sub : alu_add;
      f3_sll:  return alu_sll;
      f3_slt:  return alu_slt;
      f3_sltu: return alu_sltu;
      f3_xor:  return alu_xor;
      f3_srl:  return alt_shift ? alu_sra : alu_srl;
      f3_or:   return alu_or;
      f3_and:  return alu_and;
      default: return alu_add;
    endcase
  endfunction

  assign opcode = instr.r_view.opcode;
  assign funct3 = instr.r_view.funct3;
  assign rs1    = instr.r_view.rs1;
  assign rs2    = instr.r_view.rs2;
  assign alt    = (instr.r_view.funct7 == alt_funct7);

  assign imm_i = {{20{instr.i_view.imm11_0[11]}}, instr.i_view.imm11_0};
  assign imm_s = {{20{instr.s_view.imm11_5[6]}}, instr.s_view.imm11_5, instr.s_view.imm4_0};
  assign imm_u = {instr[31:12], 12'b0};

  // ************************************************************************
  // control decode. anything unknown leaves all enables low.
  // ************************************************************************
  always_comb begin
    alu_op    = alu_add;
    imm       = imm_i;
    use_imm   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    case (opcode)
      opc_op: begin
        alu_op    = arith_op(funct3, alt, alt);
        reg_write = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
      end
      opc_op_imm: begin
        alu_op    = arith_op(funct3, 1'b0, alt);  // no subi.
        use_imm   = 1'b1;
        reg_write = 1'b1;
        uses_rs1  = 1'b1;
      end
      opc_lui: begin
        alu_op    = alu_pass_b;
        imm       = imm_u;
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      opc_load: begin
        use_imm   = (funct3 == f3_word);
        mem_read  = (funct3 == f3_word);
        reg_write = (funct3 == f3_word);
        uses_rs1  = (funct3 == f3_word);
      end
      opc_store: begin
        imm       = imm_s;
        use_imm   = (funct3 == f3_word);
        mem_write = (funct3 == f3_word);
        uses_rs1  = (funct3 == f3_word);
        uses_rs2  = (funct3 == f3_word);
      end
      default: ;
    endcase
  end

  assign stall = ex_is_load && (ex_load_rd != '0) &&
                 ((uses_rs1 && ex_load_rd == rs1) || (uses_rs2 && ex_load_rd == rs2));

  // register file with write-first read.
  always_ff @(posedge clk) begin
    if (wb.reg_write && wb.rd != '0)
      regs[wb.rd] <= wb.wdata;
  end

  assign rs1_data = (rs1 == '0) ? '0 :
                    (wb.reg_write && wb.rd == rs1) ? wb.wdata : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (wb.reg_write && wb.rd == rs2) ? wb.wdata : regs[rs2];

  // unused source fields go out as x0 so they never hit a forward.
  always_ff @(posedge clk) begin
    if (!rst_n || stall) begin  // bubble.
      dx.rs1       <= '0;
      dx.rs2       <= '0;
      dx.mem_read  <= 1'b0;
      dx.mem_write <= 1'b0;
      dx.reg_write <= 1'b0;
    end else begin
      dx.rs1       <= uses_rs1 ? rs1 : '0;
      dx.rs2       <= uses_rs2 ? rs2 : '0;
      dx.mem_read  <= mem_read;
      dx.mem_write <= mem_write;
      dx.reg_write <= reg_write;
    end
  end

  always_ff @(posedge clk) begin
    dx.rd       <= instr.r_view.rd;
    dx.rs1_data <= rs1_data;
    dx.rs2_data <= rs2_data;
    dx.imm      <= imm;
    dx.alu_op   <= alu_op;
    dx.use_imm  <= use_imm;
  end

  // the bubble clears the load from execute.
  a_stall_single: assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall);

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import rv_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  dec_ex_bus.dst  dx,
  ex_mem_bus.fwd  mem_fwd,
  wb_bus.fwd      wb_fwd,
  ex_mem_bus.src  xm
);

  logic [1:0]      fwd_a;
  logic [1:0]      fwd_b;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_out;

  // nearest producer wins.
  function automatic logic [1:0] fwd_sel(
    input logic [reg_addr_w-1:0] rs,
    input logic                  mem_we,
    input logic [reg_addr_w-1:0] mem_rd,
    input logic                  wb_we,
    input logic [reg_addr_w-1:0] wb_rd
  );
    if (rs == '0)
      return fwd_reg;
    if (mem_we && mem_rd == rs)
      return fwd_mem;
    if (wb_we && wb_rd == rs)
      return fwd_wb;
    return fwd_reg;
  endfunction

  function automatic logic [xlen-1:0] fwd_mux(
    input logic [1:0]      sel,
    input logic [xlen-1:0] reg_val,
    input logic [xlen-1:0] mem_val,
    input logic [xlen-1:0] wb_val
  );
    case (sel)
      fwd_mem: return mem_val;
      fwd_wb:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign fwd_a = fwd_sel(dx.rs1, mem_fwd.reg_write, mem_fwd.rd, wb_fwd.reg_write, wb_fwd.rd);
  assign fwd_b = fwd_sel(dx.rs2, mem_fwd.reg_write, mem_fwd.rd, wb_fwd.reg_write, wb_fwd.rd);

  assign op_a    = fwd_mux(fwd_a, dx.rs1_data, mem_fwd.result, wb_fwd.wdata);
  assign rs2_val = fwd_mux(fwd_b, dx.rs2_data, mem_fwd.result, wb_fwd.wdata);
  assign op_b    = dx.use_imm ? dx.imm : rs2_val;

  always_comb begin
    case (dx.alu_op)
      alu_add:    alu_out = op_a + op_b;
      alu_sub:    alu_out = op_a - op_b;
      alu_sll:    alu_out = op_a << op_b[4:0];
      alu_slt:    alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_out = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:    alu_out = op_a ^ op_b;
      alu_srl:    alu_out = op_a >> op_b[4:0];
      alu_sra:    alu_out = $signed(op_a) >>> op_b[4:0];
      alu_or:     alu_out = op_a | op_b;
      alu_and:    alu_out = op_a & op_b;
      alu_pass_b: alu_out = op_b;
      default:    alu_out = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      xm.mem_read  <= 1'b0;
      xm.mem_write <= 1'b0;
      xm.reg_write <= 1'b0;
    end else begin
      xm.mem_read  <= dx.mem_read;
      xm.mem_write <= dx.mem_write;
      xm.reg_write <= dx.reg_write;
    end
  end

  always_ff @(posedge clk) begin
    xm.rd         <= dx.rd;
    xm.result     <= alu_out;
    xm.store_data <= rs2_val;  // forwarded store data.
  end

  // load data is not ready yet. decode must have stalled.
  a_no_load_fwd: assert property (@(posedge clk) disable iff (!rst_n)
    xm.mem_read |-> (fwd_a != fwd_mem && fwd_b != fwd_mem));

endmodule

`default_nettype wire

// File: source/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

module memory_stage import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  ex_mem_bus.dst          xm,
  output logic [xlen-1:0] dmem_addr,
  output logic [xlen-1:0] dmem_wdata,
  output logic            dmem_read,
  output logic            dmem_write,
  input  logic [xlen-1:0] dmem_rdata,
  wb_bus.src              wb
);

  logic [xlen-1:0] wb_value;

  assign dmem_addr  = xm.result;  // alu computed rs1 + imm.
  assign dmem_wdata = xm.store_data;
  assign dmem_read  = xm.mem_read;
  assign dmem_write = xm.mem_write;

  assign wb_value = xm.mem_read ? dmem_rdata : xm.result;

  always_ff @(posedge clk) begin
    if (!rst_n)
      wb.reg_write <= 1'b0;
    else
      wb.reg_write <= xm.reg_write;
  end

  always_ff @(posedge clk) begin
    wb.rd    <= xm.rd;
    wb.wdata <= wb_value;
  end

  a_rw_excl: assert property (@(posedge clk) disable iff (!rst_n) !(dmem_read && dmem_write));

endmodule

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  output logic [xlen-1:0] imem_addr,
  input  logic [xlen-1:0] imem_instr,
  output logic [xlen-1:0] dmem_addr,
  output logic [xlen-1:0] dmem_wdata,
  output logic            dmem_read,
  output logic            dmem_write,
  input  logic [xlen-1:0] dmem_rdata
);

  instr_u                fd_instr;
  logic                  stall;
  logic [reg_addr_w-1:0] ex_load_rd;
  logic                  ex_is_load;

  dec_ex_bus dx_bus ();
  ex_mem_bus xm_bus ();
  wb_bus     wb_bus_i ();

  // load-use check looks at the instruction now in execute.
  assign ex_load_rd = dx_bus.rd;
  assign ex_is_load = dx_bus.mem_read;

  fetch_stage u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .imem_addr  (imem_addr),
    .imem_instr (imem_instr),
    .instr      (fd_instr)
  );

  decode_stage u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr      (fd_instr),
    .wb         (wb_bus_i),
    .ex_load_rd (ex_load_rd),
    .ex_is_load (ex_is_load),
    .stall      (stall),
    .dx         (dx_bus)
  );

  execute_stage u_execute (
    .clk     (clk),
    .rst_n   (rst_n),
    .dx      (dx_bus),
    .mem_fwd (xm_bus),
    .wb_fwd  (wb_bus_i),
    .xm      (xm_bus)
  );

  memory_stage u_memory (
    .clk        (clk),
    .rst_n      (rst_n),
    .xm         (xm_bus),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_read  (dmem_read),
    .dmem_write (dmem_write),
    .dmem_rdata (dmem_rdata),
    .wb         (wb_bus_i)
  );

endmodule

`default_nettype wire

// File: bench/rv_ref_model.svh
`ifndef rv_ref_model_svh
`define rv_ref_model_svh

// ************************************************************************
// instruction level model of the rv32i subset.
// ************************************************************************
function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  logic [31:0] sra;
  sra = $signed(a) >>> b[4:0];  // kept apart so the shift stays signed.
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return {31'd0, $signed(a) < $signed(b)};
    3'b011:  return {31'd0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? sra : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

// runs the whole program once and lists every store in program order.
function automatic int run_reference(
  input  logic [31:0] code [prog_len],
  input  logic [31:0] mem_in [mem_words],
  output logic [31:0] st_addr [$],
  output logic [31:0] st_data [$],
  output int          st_index [$]
);
  logic [31:0] x [32];
  logic [31:0] mem [mem_words];
  logic [31:0] ins;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] addr;
  logic [31:0] r;
  logic        wr;
  mem = mem_in;
  st_addr  = {};
  st_data  = {};
  st_index = {};
  for (int i = 0; i < 32; i++)
    x[i] = 32'd0;
  for (int pc = 0; pc < prog_len; pc++) begin
    ins   = code[pc];
    a     = x[ins[19:15]];
    b     = x[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    wr    = 1'b1;
    r     = 32'd0;
    case (ins[6:0])
      op_rr:  r = ref_alu(ins[14:12], ins[30], a, b);
      op_ri:  r = ref_alu(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
      op_lui: r = {ins[31:12], 12'd0};
      op_lw: begin
        addr = a + imm_i;
        r    = mem[addr[9:2]];
      end
      op_sw: begin
        addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        mem[addr[9:2]] = b;
        st_addr.push_back(addr);
        st_data.push_back(b);
        st_index.push_back(pc);
        wr = 1'b0;
      end
      default: wr = 1'b0;  // anything else is a bubble.
    endcase
    if (wr && ins[11:7] != 5'd0)
      x[ins[11:7]] = r;
  end
  return st_addr.size();
endfunction

`endif

// File: bench/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

  localparam int          prog_len    = 256;
  localparam int          mem_words   = 256;  // address bits 9:2.
  localparam int          cycle_limit = 10 + 2 * prog_len + 20;
  localparam int          n_tests     = 6;
  localparam logic [31:0] seed        = 32'he66e;
  localparam logic [31:0] nop_word    = 32'h00000013;
  localparam logic [6:0]  op_rr       = 7'b0110011;
  localparam logic [6:0]  op_ri       = 7'b0010011;
  localparam logic [6:0]  op_lui      = 7'b0110111;
  localparam logic [6:0]  op_lw       = 7'b0000011;
  localparam logic [6:0]  op_sw       = 7'b0100011;

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_instr;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_read;
  logic        dmem_write;
  logic [31:0] dmem_rdata;

  logic [31:0] prog [prog_len];
  int          test_of [prog_len];
  logic [31:0] dmem [mem_words];
  logic [31:0] dmem_start [mem_words];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          exp_index [$];
  int          last_of [n_tests];
  int          errs [n_tests];
  string       test_name [n_tests] = '{"reset", "register ops", "immediate ops",
                                       "forwarding", "load-use", "store sequence"};
  int          n_instr;
  int          n_exp = 0;
  int          n_seen = 0;
  int          cycles = 0;
  bit          seen_run = 1'b0;
  bit          seen_store = 1'b0;

  `include "rv_ref_model.svh"

  rv_core UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_instr (imem_instr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_read  (dmem_read),
    .dmem_write (dmem_write),
    .dmem_rdata (dmem_rdata)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // zero-wait memories. read data only comes back while dmem_read is high.
  assign imem_instr = (imem_addr[31:10] == '0) ? prog[imem_addr[9:2]] : nop_word;
  assign dmem_rdata = (dmem_read === 1'b1) ? dmem[dmem_addr[9:2]] : '0;

  always @(posedge clk) begin
    if (dmem_write === 1'b1)
      dmem[dmem_addr[9:2]] <= dmem_wdata;
  end

  // ************************************************************************
  // program generation.
  // ************************************************************************
  // op 0..9 is add, sub, sll, slt, sltu, xor, srl, sra, or, and.
  function automatic logic [31:0] encode_rr(input int op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = (op == 1 || op == 7) ? 7'h20 : 7'h00;
    f3 = 3'(op == 0 ? 0 : (op < 7 ? op - 1 : op - 2));
    return {f7, rs2, rs1, f3, rd, op_rr};
  endfunction

  function automatic logic [31:0] encode_i(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_sw(input logic [4:0] rs2, input logic [11:0] off);
    return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], op_sw};
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'(1 + $urandom % 31);
  endfunction

  function automatic logic [11:0] rand_off();
    return 12'({8'($urandom), 2'b00});
  endfunction

  task automatic emit(input logic [31:0] word, input int test);
    prog[n_instr]    = word;
    test_of[n_instr] = test;
    n_instr++;
  endtask

  task automatic build_program();
    logic [4:0]  a;
    logic [4:0]  b;
    logic [4:0]  c;
    logic [11:0] imm;
    for (int i = 0; i < prog_len; i++) begin
      prog[i]    = nop_word;
      test_of[i] = 5;
    end
    n_instr = 0;
    for (int r = 1; r < 32; r++) begin  // random start values.
      emit({20'($urandom), 5'(r), op_lui}, 1);
      emit(encode_i(op_ri, 3'b000, 5'(r), 5'(r), 12'($urandom)), 1);
    end
    for (int k = 0; k < 20; k++) begin
      a = rand_reg();
      emit(encode_rr(k % 10, a, rand_reg(), rand_reg()), 1);
      emit(encode_sw(a, rand_off()), 1);
    end
    for (int k = 0; k < 9; k++) begin  // addi slli slti sltiu xori srli srai ori andi.
      a = rand_reg();
      if (k == 1 || k == 5 || k == 6)
        imm = {(k == 6) ? 7'h20 : 7'h00, 5'($urandom)};
      else
        imm = {(k % 2 == 0), 11'($urandom)};
      emit(encode_i(op_ri, 3'(k < 6 ? k : k - 1), a, rand_reg(), imm), 2);
      emit(encode_sw(a, rand_off()), 2);
    end
    a = rand_reg();
    emit({20'($urandom), a, op_lui}, 2);
    emit(encode_sw(a, rand_off()), 2);
    emit(encode_i(op_ri, 3'b000, 5'd0, rand_reg(), 12'h7ff), 2);
    emit(encode_rr(0, 5'd0, rand_reg(), rand_reg()), 2);
    emit(encode_sw(5'd0, rand_off()), 2);
    for (int g = 0; g < 4; g++) begin  // distance one and two on both operands.
      a = 5'(1 + $urandom % 28);
      emit(encode_rr(int'($urandom % 10), a, rand_reg(), rand_reg()), 3);
      emit(encode_rr(int'($urandom % 10), a + 5'd1, a, rand_reg()), 3);
      emit(encode_rr(int'($urandom % 10), a + 5'd2, rand_reg(), a), 3);
      emit(encode_rr(int'($urandom % 10), a + 5'd3, a + 5'd1, a + 5'd2), 3);
      emit(encode_sw(a + 5'd3, rand_off()), 3);
      emit(encode_sw(a + 5'd1, rand_off()), 3);
      emit(encode_sw(a + 5'd2, rand_off()), 3);
    end
    for (int g = 0; g < 3; g++) begin
      a = rand_reg();
      b = rand_reg();
      c = rand_reg();
      emit(encode_i(op_lw, 3'b010, a, 5'd0, rand_off()), 4);
      emit(encode_rr(int'($urandom % 10), b, a, rand_reg()), 4);
      emit(encode_sw(b, rand_off()), 4);
      emit(encode_i(op_lw, 3'b010, c, 5'd0, rand_off()), 4);
      emit(encode_rr(int'($urandom % 10), b, rand_reg(), c), 4);
      emit(encode_sw(b, rand_off()), 4);
      emit(encode_i(op_lw, 3'b010, a, 5'd0, rand_off()), 4);
      emit(encode_sw(a, rand_off()), 4);  // loaded value straight to store data.
    end
    for (int r = 0; r < 32; r++)
      emit(encode_sw(5'(r), rand_off()), 5);
  endtask

  // ************************************************************************
  // checking.
  // ************************************************************************
  task automatic report_test(input int t);
    if (errs[t] == 0)
      $display("test %0d %s: pass", t, test_name[t]);
    else
      $display("test %0d %s: %0d error(s)", t, test_name[t], errs[t]);
  endtask

  task automatic check_store();
    int t;
    if (n_seen >= n_exp) begin
      $display("%0t: extra store of %h to %h after all %0d expected stores",
               $time, dmem_wdata, dmem_addr, n_exp);
      errs[5]++;
    end else begin
      t = test_of[exp_index[n_seen]];
      if (dmem_addr !== exp_addr[n_seen] || dmem_wdata !== exp_data[n_seen]) begin
        $display("[FAIL] %0t: store %0d wrote %h to %h, expected %h to %h", $time, n_seen,
                 dmem_wdata, dmem_addr, exp_data[n_seen], exp_addr[n_seen]);
        errs[t]++;
      end
      if (n_seen == last_of[t] && t != 5)
        report_test(t);
    end
    n_seen++;
  endtask

  // outputs settle well before the falling edge.
  always @(negedge clk) begin
    if (!rst_n) begin
      if (dmem_write !== 1'b0 || dmem_read !== 1'b0) begin
        $display("[FAIL] %0t: data memory strobe high during reset", $time);
        errs[0]++;
      end
    end else begin
      if (!seen_run) begin
        seen_run = 1'b1;
        if (imem_addr !== 32'd0) begin
          $display("[FAIL] %0t: imem_addr %h after reset, expected 0", $time, imem_addr);
          errs[0]++;
        end
      end
      if (!seen_store && dmem_read !== 1'b0) begin
        $display("[FAIL] %0t: dmem_read high before the first store", $time);
        errs[0]++;
      end
      if (dmem_write === 1'b1) begin
        if (!seen_store) begin
          seen_store = 1'b1;
          report_test(0);
        end
        check_store();
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d of %0d stores seen", cycles, n_seen, n_exp);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int total;
    int passed;
    rst_n = 1'b0;
    void'($urandom(seed));
    for (int i = 0; i < mem_words; i++) begin
      dmem[i]       = $urandom;
      dmem_start[i] = dmem[i];
    end
    for (int t = 0; t < n_tests; t++) begin
      last_of[t] = -1;
      errs[t]    = 0;
    end
    build_program();
    n_exp = run_reference(prog, dmem_start, exp_addr, exp_data, exp_index);
    for (int i = 0; i < n_exp; i++)
      last_of[test_of[exp_index[i]]] = i;
    repeat (10) @(posedge clk);
    #2 rst_n = 1'b1;
    while (n_seen < n_exp)
      @(posedge clk);
    repeat (10) @(posedge clk);  // leave room for a stray extra store.
    report_test(5);
    total  = 0;
    passed = 0;
    for (int t = 0; t < n_tests; t++) begin
      total += errs[t];
      if (errs[t] == 0)
        passed++;
    end
    $display("%0d of %0d tests passed, %0d errors, %0d stores seen, %0d expected",
             passed, n_tests, total, n_seen, n_exp);
    if (total == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+bench
source/rv_pkg.sv
source/pipe_buses.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/rv_core.sv
bench/tb_rv_core.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_rv_core
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
